// File: build.f
hw/vseq_pkg.sv
hw/vseq_decode.sv
hw/vseq_scoreboard.sv
hw/vseq_id_tracker.sv
hw/vseq_unit_credits.sv
hw/vseq_issue.sv
hw/vseq_top.sv
sim/vseq_tb.sv

// File: hw/vseq_decode.sv
`timescale 1ns/1ns

module vseq_decode (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Dispatcher side
  input  vseq_pkg::insn_req_t   req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Issue stage side
  output vseq_pkg::dec_insn_t   dec_o,
  output logic                  dec_valid_o,
  input  logic                  dec_ready_i
);

  import vseq_pkg::*;

  // Pipeline register of the stage
  dec_insn_t dec_q;
  logic      dec_valid_q;

  // Every opcode runs on exactly one unit
  function automatic unit_e unit_of(vseq_op_e op);
    unit_e unit;
    unique case (op)
      VADD:                 unit = UNIT_ALU;
      VMUL:                 unit = UNIT_MUL;
      VLE:                  unit = UNIT_LOAD;
      VSE:                  unit = UNIT_STORE;
      VSLIDEUP, VSLIDEDOWN: unit = UNIT_SLIDE;
      default:              unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

  // Accept when the register is empty or emptied in this cycle
  assign req_ready_o = !dec_valid_q || dec_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      dec_valid_q <= 1'b1;
    end else if (dec_ready_i) begin
      dec_valid_q <= 1'b0;
    end
  end

  // Payload only moves on a transfer
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      dec_q <= '{insn: req_i, unit: unit_of(req_i.op)};
    end
  end

  assign dec_o       = dec_q;
  assign dec_valid_o = dec_valid_q;

  // A stalled decoded instruction must reach the issue stage unchanged
  a_dec_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_o));

endmodule

// File: hw/vseq_id_tracker.sv
`timescale 1ns/1ns

module vseq_id_tracker (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              issue_fire_i,
  output vseq_pkg::vid_t    issue_id_o,
  output logic              full_o,
  input  vseq_pkg::vmask_t  hazard_union_i,
  input  vseq_pkg::done_t   done_i,
  output vseq_pkg::vmask_t  running_o,
  output logic              idle_o
);

  import vseq_pkg::*;

  vmask_t running_d, running_q;
  // Row N lists the instructions that instruction N waits on
  vmask_t [NrVInsn-1:0] dep_d, dep_q;
  vmask_t done_mask;
  logic   dep_orphan;

  // Lowest clear bit of the running set, scanned from the top so the last hit wins
  always_comb begin
    issue_id_o = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_q[i]) issue_id_o = vid_t'(i);
    end
  end

  assign full_o    = &running_q;
  assign idle_o    = ~|running_q;
  assign running_o = running_q;

  always_comb begin
    done_mask = '0;
    if (done_i.valid) done_mask[done_i.vid] = 1'b1;
    running_d = running_q & ~done_mask;
    // A completion releases everyone that waited on it
    for (int i = 0; i < NrVInsn; i++) begin
      dep_d[i] = dep_q[i] & ~done_mask;
    end
    if (done_i.valid) dep_d[done_i.vid] = '0;
    // The new ID comes from the bitmap before the completion
    if (issue_fire_i) begin
      running_d[issue_id_o] = 1'b1;
      dep_d[issue_id_o]     = hazard_union_i & ~done_mask;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= '0;
      dep_q     <= '0;
    end else begin
      running_q <= running_d;
      dep_q     <= dep_d;
    end
  end

  // Any dependency still pointing at an instruction that has left
  always_comb begin
    dep_orphan = 1'b0;
    for (int i = 0; i < NrVInsn; i++) begin
      dep_orphan |= |(dep_q[i] & ~running_q);
    end
  end

  // Units only retire instructions the sequencer handed out
  a_done_running: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i.valid |-> running_q[done_i.vid]);

  // The scoreboard only reports hazards on live IDs, so the table stays clean
  a_dep_live: assert property (@(posedge clk_i) disable iff (!rst_ni) !dep_orphan);

endmodule

// File: hw/vseq_issue.sv
`timescale 1ns/1ns

module vseq_issue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Decode stage side
  input  vseq_pkg::dec_insn_t   dec_i,
  input  logic                  dec_valid_i,
  output logic                  dec_ready_o,
  // Hazards and resources for the waiting instruction
  input  vseq_pkg::vmask_t      hazard_vs1_i,
  input  vseq_pkg::vmask_t      hazard_vs2_i,
  input  vseq_pkg::vmask_t      hazard_vd_i,
  input  vseq_pkg::vid_t        issue_id_i,
  input  logic                  full_i,
  input  vseq_pkg::unit_vec_t   unit_ready_i,
  // Tracker update
  output logic                  issue_fire_o,
  output vseq_pkg::vmask_t      hazard_union_o,
  // Functional unit side
  output vseq_pkg::issue_req_t  issue_o,
  output logic                  issue_valid_o,
  input  logic                  issue_ready_i
);

  import vseq_pkg::*;

  logic out_free;
  logic src_hazard, any_hazard, no_src;
  logic stall;

  // Output register is empty or leaves in this cycle
  assign out_free = !issue_valid_o || issue_ready_i;

  assign src_hazard     = |(hazard_vs1_i | hazard_vs2_i);
  assign hazard_union_o = hazard_vs1_i | hazard_vs2_i | hazard_vd_i;
  assign any_hazard     = |hazard_union_o;
  assign no_src         = !dec_i.insn.use_vs1 && !dec_i.insn.use_vs2;

  ////////////////////
  // Stall rules
  ////////////////////

  // Slides cannot chain on their inputs, slide-up not even on its destination
  // An instruction without sources has nothing to chain on, so it waits for all hazards
  assign stall = full_i
              || !unit_ready_i[dec_i.unit]
              || (dec_i.insn.op == VSLIDEUP && any_hazard)
              || (dec_i.insn.op == VSLIDEDOWN && src_hazard)
              || (no_src && any_hazard);

  assign dec_ready_o  = out_free && !stall;
  assign issue_fire_o = dec_valid_i && dec_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_valid_o <= 1'b0;
    end else if (issue_fire_o) begin
      issue_valid_o <= 1'b1;
    end else if (issue_ready_i) begin
      issue_valid_o <= 1'b0;
    end
  end

  // Request is captured with the hazards seen in the firing cycle
  always_ff @(posedge clk_i) begin
    if (issue_fire_o) begin
      issue_o <= '{
        id:         issue_id_i,
        op:         dec_i.insn.op,
        unit:       dec_i.unit,
        vd:         dec_i.insn.vd,
        vs1:        dec_i.insn.vs1,
        vs2:        dec_i.insn.vs2,
        hazard_vs1: hazard_vs1_i,
        hazard_vs2: hazard_vs2_i,
        hazard_vd:  hazard_vd_i
      };
    end
  end

  // Back-pressure from the unit must not disturb the pending request
  a_issue_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid_o && !issue_ready_i |=> issue_valid_o && $stable(issue_o));

endmodule

// File: hw/vseq_pkg.sv
package vseq_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Instructions that can be in flight at once
  localparam int unsigned NrVInsn  = 8;
  // Architectural vector registers
  localparam int unsigned NrVRegs  = 32;
  // Functional units behind the sequencer
  localparam int unsigned NrUnits  = 5;
  // Occupancy counters are wide enough for the deepest queue
  localparam int unsigned CntWidth = 3;

  // Queue depth per unit, indexed by unit_e (ALU in the lowest slot)
  localparam logic [NrUnits-1:0][CntWidth-1:0] UnitQueueDepth = {
    3'd1,  // slide
    3'd2,  // store
    3'd2,  // load
    3'd4,  // multiplier
    3'd4   // ALU
  };

  ////////////////////
  // Types
  ////////////////////

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  // One bit per instruction ID, used for hazards and the running set
  typedef logic [NrVInsn-1:0]         vmask_t;
  typedef logic [NrUnits-1:0]         unit_vec_t;

  typedef enum logic [2:0] {
    VADD,
    VMUL,
    VLE,
    VSE,
    VSLIDEUP,
    VSLIDEDOWN
  } vseq_op_e;

  // Values double as the index into unit_vec_t and UnitQueueDepth
  typedef enum logic [2:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_LOAD,
    UNIT_STORE,
    UNIT_SLIDE
  } unit_e;

  // Instruction as it arrives from the dispatcher
  typedef struct packed {
    vseq_op_e op;
    vreg_t    vd;
    vreg_t    vs1;
    vreg_t    vs2;
    logic     use_vd;
    logic     use_vs1;
    logic     use_vs2;
  } insn_req_t;

  // Decoded instruction, the request plus its target unit
  typedef struct packed {
    insn_req_t insn;
    unit_e     unit;
  } dec_insn_t;

  // Request handed to a functional unit
  typedef struct packed {
    vid_t     id;
    vseq_op_e op;
    unit_e    unit;
    vreg_t    vd;
    vreg_t    vs1;
    vreg_t    vs2;
    vmask_t   hazard_vs1;
    vmask_t   hazard_vs2;
    vmask_t   hazard_vd;
  } issue_req_t;

  // Completion reported by a unit
  typedef struct packed {
    logic  valid;
    vid_t  vid;
    unit_e unit;
  } done_t;

endpackage

// File: hw/vseq_scoreboard.sv
`timescale 1ns/1ns

module vseq_scoreboard (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Instruction waiting in the issue stage
  input  vseq_pkg::dec_insn_t dec_i,
  input  logic                issue_fire_i,
  input  vseq_pkg::vid_t      issue_id_i,
  // Instructions still in flight
  input  vseq_pkg::vmask_t    running_i,
  output vseq_pkg::vmask_t    hazard_vs1_o,
  output vseq_pkg::vmask_t    hazard_vs2_o,
  output vseq_pkg::vmask_t    hazard_vd_o
);

  import vseq_pkg::*;

  // Last instruction that touched a register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  vreg_access_t [NrVRegs-1:0] write_list_d, write_list_q;
  vreg_access_t [NrVRegs-1:0] read_list_d,  read_list_q;

  // Entries only count while their instruction is still running
  logic [NrVRegs-1:0] write_live, read_live;

  always_comb begin
    for (int r = 0; r < NrVRegs; r++) begin
      write_live[r] = write_list_q[r].valid && running_i[write_list_q[r].vid];
      read_live[r]  = read_list_q[r].valid && running_i[read_list_q[r].vid];
    end
  end

  ////////////////////
  // Hazards
  ////////////////////

  always_comb begin
    hazard_vs1_o = '0;
    hazard_vs2_o = '0;
    hazard_vd_o  = '0;
    // RAW on the sources
    if (dec_i.insn.use_vs1 && write_live[dec_i.insn.vs1]) begin
      hazard_vs1_o[write_list_q[dec_i.insn.vs1].vid] = 1'b1;
    end
    if (dec_i.insn.use_vs2 && write_live[dec_i.insn.vs2]) begin
      hazard_vs2_o[write_list_q[dec_i.insn.vs2].vid] = 1'b1;
    end
    if (dec_i.insn.use_vd) begin
      // WAR: the pending reader blocks every operand
      if (read_live[dec_i.insn.vd]) begin
        hazard_vs1_o[read_list_q[dec_i.insn.vd].vid] = 1'b1;
        hazard_vs2_o[read_list_q[dec_i.insn.vd].vid] = 1'b1;
        hazard_vd_o[read_list_q[dec_i.insn.vd].vid]  = 1'b1;
      end
      // WAW against the pending writer
      if (write_live[dec_i.insn.vd]) begin
        hazard_vd_o[write_list_q[dec_i.insn.vd].vid] = 1'b1;
      end
    end
  end

  ////////////////////
  // List update
  ////////////////////

  always_comb begin
    // Drop entries of retired instructions before an ID can be handed out again
    for (int r = 0; r < NrVRegs; r++) begin
      write_list_d[r] = '{vid: write_list_q[r].vid, valid: write_live[r]};
      read_list_d[r]  = '{vid: read_list_q[r].vid, valid: read_live[r]};
    end
    if (issue_fire_i) begin
      if (dec_i.insn.use_vd) write_list_d[dec_i.insn.vd] = '{vid: issue_id_i, valid: 1'b1};
      if (dec_i.insn.use_vs1) read_list_d[dec_i.insn.vs1] = '{vid: issue_id_i, valid: 1'b1};
      if (dec_i.insn.use_vs2) read_list_d[dec_i.insn.vs2] = '{vid: issue_id_i, valid: 1'b1};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      write_list_q <= '0;
      read_list_q  <= '0;
    end else begin
      write_list_q <= write_list_d;
      read_list_q  <= read_list_d;
    end
  end

endmodule

// File: hw/vseq_top.sv
`timescale 1ns/1ns

module vseq_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vseq_pkg::insn_req_t   req_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  output vseq_pkg::issue_req_t  issue_o,
  output logic                  issue_valid_o,
  input  logic                  issue_ready_i,
  input  vseq_pkg::done_t       done_i,
  output logic                  idle_o
);

  import vseq_pkg::*;

  // Decode to issue
  dec_insn_t dec;
  logic      dec_valid, dec_ready;

  // Issue stage to and from the trackers
  logic      issue_fire;
  vid_t      issue_id;
  logic      full;
  vmask_t    hazard_vs1, hazard_vs2, hazard_vd, hazard_union;
  vmask_t    running;
  unit_vec_t unit_ready;

  ////////////////////
  // Pipeline
  ////////////////////

  vseq_decode i_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .dec_o       (dec),
    .dec_valid_o (dec_valid),
    .dec_ready_i (dec_ready)
  );

  vseq_issue i_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .dec_i          (dec),
    .dec_valid_i    (dec_valid),
    .dec_ready_o    (dec_ready),
    .hazard_vs1_i   (hazard_vs1),
    .hazard_vs2_i   (hazard_vs2),
    .hazard_vd_i    (hazard_vd),
    .issue_id_i     (issue_id),
    .full_i         (full),
    .unit_ready_i   (unit_ready),
    .issue_fire_o   (issue_fire),
    .hazard_union_o (hazard_union),
    .issue_o        (issue_o),
    .issue_valid_o  (issue_valid_o),
    .issue_ready_i  (issue_ready_i)
  );

  ////////////////////
  // Trackers
  ////////////////////

  // Hazards look at the instruction waiting in the issue stage
  vseq_scoreboard i_scoreboard (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .dec_i        (dec),
    .issue_fire_i (issue_fire),
    .issue_id_i   (issue_id),
    .running_i    (running),
    .hazard_vs1_o (hazard_vs1),
    .hazard_vs2_o (hazard_vs2),
    .hazard_vd_o  (hazard_vd)
  );

  vseq_id_tracker i_id_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_fire_i   (issue_fire),
    .issue_id_o     (issue_id),
    .full_o         (full),
    .hazard_union_i (hazard_union),
    .done_i         (done_i),
    .running_o      (running),
    .idle_o         (idle_o)
  );

  vseq_unit_credits i_unit_credits (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_fire_i (issue_fire),
    .issue_unit_i (dec.unit),
    .done_i       (done_i),
    .unit_ready_o (unit_ready)
  );

endmodule

// File: hw/vseq_unit_credits.sv
`timescale 1ns/1ns

module vseq_unit_credits (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                issue_fire_i,
  input  vseq_pkg::unit_e     issue_unit_i,
  input  vseq_pkg::done_t     done_i,
  output vseq_pkg::unit_vec_t unit_ready_o
);

  import vseq_pkg::*;

  // Instructions sitting in each unit's queue
  logic [NrUnits-1:0][CntWidth-1:0] cnt_q;
  unit_vec_t                        cnt_up, cnt_down;

  for (genvar u = 0; u < NrUnits; u++) begin : gen_unit_cnt
    assign cnt_up[u]   = issue_fire_i && (issue_unit_i == unit_e'(u));
    assign cnt_down[u] = done_i.valid && (done_i.unit == unit_e'(u));

    // An issue and a completion in one cycle cancel out
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[u] <= '0;
      end else if (cnt_up[u] && !cnt_down[u]) begin
        cnt_q[u] <= cnt_q[u] + 1'b1;
      end else if (cnt_down[u] && !cnt_up[u]) begin
        cnt_q[u] <= cnt_q[u] - 1'b1;
      end
    end

    // Room left in the queue
    assign unit_ready_o[u] = cnt_q[u] < UnitQueueDepth[u];

    // The issue stall keeps the count within depth and completions match issues
    a_cnt_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cnt_q[u] <= UnitQueueDepth[u] && !(cnt_down[u] && !cnt_up[u] && cnt_q[u] == '0));
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module vseq_tb -o vseq_sim
./obj_dir/vseq_sim | tee sim.log
if grep -q "\*\* PASS \*\*" sim.log; then
  exit 0
else
  exit 1
fi

// File: sim/vseq_tb.sv
`timescale 1ns/1ns

module vseq_tb;

  import vseq_pkg::*;

  localparam int unsigned Timeout = 200;

  // One expected issue request, in the order instructions were accepted
  typedef struct packed {
    vid_t     id;
    vseq_op_e op;
    unit_e    unit;
    vreg_t    vd;
    vreg_t    vs1;
    vreg_t    vs2;
    vmask_t   hazard_vs1;
    vmask_t   hazard_vs2;
    vmask_t   hazard_vd;
  } expect_t;

  logic       clk_i;
  logic       rst_ni;
  insn_req_t  req_i;
  logic       req_valid_i;
  logic       req_ready_o;
  issue_req_t issue_o;
  logic       issue_valid_o;
  logic       issue_ready_i;
  done_t      done_i;
  logic       idle_o;

  expect_t      exp_q[$];
  logic [NrVInsn-1:0] issued;
  int           tests;
  int           errors;
  integer       seed;

  vseq_top vseq_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o),
    .issue_ready_i (issue_ready_i),
    .done_i        (done_i),
    .idle_o        (idle_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Unit that each opcode belongs to
  function automatic unit_e unit_for_op(vseq_op_e op);
    if (op == VMUL) return UNIT_MUL;
    if (op == VLE) return UNIT_LOAD;
    if (op == VSE) return UNIT_STORE;
    if (op == VSLIDEUP || op == VSLIDEDOWN) return UNIT_SLIDE;
    return UNIT_ALU;
  endfunction

  task automatic next_cycle;
    @(posedge clk_i);
    #1;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout after %0d cycles while waiting for %s", Timeout, what);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic check_vid(input string name, input vid_t got, input vid_t exp, inout bit ok);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic check_op(input string name, input vseq_op_e got, input vseq_op_e exp,
                          inout bit ok);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic check_vreg(input string name, input vreg_t got, input vreg_t exp,
                            inout bit ok);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic check_mask(input string name, input vmask_t got, input vmask_t exp,
                            inout bit ok);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic check_unit(input string name, input unit_e got, input unit_e exp,
                            inout bit ok);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
      ok = 1'b0;
    end
  endtask

  task automatic check_idle(input string name, input logic got, input logic exp, inout bit ok);
    if (got !== exp) begin
      $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
      ok = 1'b0;
    end
  endtask

  // Random back-pressure from the functional units
  always @(posedge clk_i) begin
    #1;
    issue_ready_i <= ($random(seed) & 3) != 0;
  end

  // Outputs are sampled at the falling edge, the transfer happens at the next rising edge
  always @(negedge clk_i) begin
    expect_t e;
    bit      ok;
    if (rst_ni && issue_valid_o && issue_ready_i) begin
      ok = 1'b1;
      tests++;
      if (exp_q.size() == 0) begin
        $display("Issue request for ID %0d arrived with none expected", issue_o.id);
        errors++;
      end else begin
        e = exp_q.pop_front();
        check_vid("issue_o.id", issue_o.id, e.id, ok);
        check_op("issue_o.op", issue_o.op, e.op, ok);
        check_unit("issue_o.unit", issue_o.unit, e.unit, ok);
        check_vreg("issue_o.vd", issue_o.vd, e.vd, ok);
        check_vreg("issue_o.vs1", issue_o.vs1, e.vs1, ok);
        check_vreg("issue_o.vs2", issue_o.vs2, e.vs2, ok);
        check_mask("issue_o.hazard_vs1", issue_o.hazard_vs1, e.hazard_vs1, ok);
        check_mask("issue_o.hazard_vs2", issue_o.hazard_vs2, e.hazard_vs2, ok);
        check_mask("issue_o.hazard_vd", issue_o.hazard_vd, e.hazard_vd, ok);
        $display("Issue of ID %0d %s", issue_o.id, ok ? "ok" : "wrong");
      end
      issued[issue_o.id] = 1'b1;
    end
  end

  ////////////////////
  // Commands
  ////////////////////

  task automatic send_insn(input insn_req_t req, input expect_t e);
    int cnt;
    bit accepted;
    cnt = 0;
    accepted = 1'b0;
    req_i = req;
    req_valid_i = 1'b1;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = req_ready_o;
      if (accepted) exp_q.push_back(e);
      next_cycle();
      cnt++;
      if (!accepted && cnt >= Timeout) stop_on_timeout("the request handshake");
    end
    req_valid_i = 1'b0;
  endtask

  // Retire once the ID is out and nothing else could still issue on its own
  task automatic retire(input vid_t vid, input unit_e unit);
    int cnt;
    bit ok;
    cnt = 0;
    ok = 1'b1;
    while (!(issued[vid] && (exp_q.size() == 0 || (vseq_top_i.dec_valid &&
           !vseq_top_i.dec_ready && !issue_valid_o)))) begin
      next_cycle();
      cnt++;
      if (cnt >= Timeout) stop_on_timeout("an ID to retire");
    end
    // The ID is still running, so the sequencer cannot be idle yet
    check_idle("idle_o", idle_o, 1'b0, ok);
    done_i = '{valid: 1'b1, vid: vid, unit: unit};
    next_cycle();
    done_i = '0;
    issued[vid] = 1'b0;
    tests++;
    $display("Retire of ID %0d %s", vid, ok ? "ok" : "wrong");
  endtask

  task automatic expect_idle;
    int cnt;
    bit ok;
    cnt = 0;
    ok = 1'b1;
    while (exp_q.size() != 0) begin
      next_cycle();
      cnt++;
      if (cnt >= Timeout) stop_on_timeout("outstanding issues before the idle check");
    end
    tests++;
    check_idle("idle_o", idle_o, 1'b1, ok);
    $display("Idle check %s", ok ? "ok" : "wrong");
  endtask

  initial begin
    int        fd;
    int        code;
    string     cmd;
    string     line;
    int        op, vd, vs1, vs2, uvd, uvs1, uvs2, id, unit;
    int        h1, h2, hd;
    insn_req_t req;
    expect_t   e;
    seed = 84;
    tests = 0;
    errors = 0;
    issued = '0;
    rst_ni = 1'b0;
    req_i = '0;
    req_valid_i = 1'b0;
    issue_ready_i = 1'b0;
    done_i = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    fd = $fopen("sim/vseq_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", cmd);
        if (code != 1) break;
        if (cmd == "#") begin
          code = $fgets(line, fd);
        end else if (cmd == "I") begin
          code = $fscanf(fd, "%d %d %d %d %d %d %d %d %h %h %h",
                         op, vd, vs1, vs2, uvd, uvs1, uvs2, id, h1, h2, hd);
          req = '{op: vseq_op_e'(op), vd: vreg_t'(vd), vs1: vreg_t'(vs1),
                  vs2: vreg_t'(vs2), use_vd: uvd[0], use_vs1: uvs1[0], use_vs2: uvs2[0]};
          e = '{id: vid_t'(id), op: vseq_op_e'(op), unit: unit_for_op(vseq_op_e'(op)),
                vd: vreg_t'(vd), vs1: vreg_t'(vs1), vs2: vreg_t'(vs2),
                hazard_vs1: vmask_t'(h1), hazard_vs2: vmask_t'(h2), hazard_vd: vmask_t'(hd)};
          send_insn(req, e);
        end else if (cmd == "R") begin
          code = $fscanf(fd, "%d %d", id, unit);
          retire(vid_t'(id), unit_e'(unit));
        end else if (cmd == "K") begin
          expect_idle();
        end else begin
          $display("Unknown command %s in the vector file", cmd);
          errors++;
        end
      end
      $fclose(fd);
    end
    $display("Tests: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: sim/vseq_vectors.txt
# I op vd vs1 vs2 use_vd use_vs1 use_vs2 exp_id haz_vs1 haz_vs2 haz_vd (masks in hex)
# R vid unit retires an ID, K checks that the sequencer is idle
I 0 1 2 3 1 1 1 0 00 00 00
I 1 4 1 5 1 1 1 1 01 00 00
I 0 2 6 7 1 1 1 2 01 01 01
I 1 4 8 9 1 1 1 3 00 00 02
R 0 0
I 2 10 0 0 1 0 0 0 00 00 00
I 2 11 0 0 1 0 0 4 00 00 00
I 2 12 0 0 1 0 0 0 00 00 00
R 0 2
I 0 13 1 2 1 1 1 5 00 04 00
R 1 1
R 2 0
R 3 1
R 4 2
R 0 2
R 5 0
K
I 5 20 0 21 1 0 1 0 00 00 00
I 5 22 0 23 1 0 1 0 00 00 00
R 0 4
R 0 4
K
I 0 5 6 7 1 1 1 0 00 00 00
I 4 8 0 5 1 0 1 0 00 00 00
R 0 0
I 3 0 0 8 0 0 1 1 00 01 00
R 0 4
R 1 3
K
